// File: build.f
+incdir+hw
hw/rd_ig_arb_pkg.sv
hw/rd_ig_req_pkg.sv
hw/rd_ig_skid_pipe.sv
hw/rd_ig_wrr_arb.sv
hw/rd_ig_out_stage.sv
hw/rd_ig_arb_top.sv
testbench/rd_ig_props.sv
testbench/tb_rd_ig.sv

// File: hw/rd_ig_arb_pkg.sv
// read ingress arbitration types: client ids, weights and client masks
`default_nettype none

`include "rd_ig_config.svh"

package rd_ig_arb_pkg;

  // index of a client, wide enough for 16
  typedef logic [3:0] client_id_t;

  // grants a client may take back to back
  // zero behaves as one
  typedef logic [7:0] weight_t;

  // one bit per client
  // used for valid, ready and grant vectors
  typedef logic [`RD_IG_NUM_CLIENTS-1:0] client_mask_t;

endpackage

`default_nettype wire

// File: hw/rd_ig_arb_top.sv
// read ingress arbiter top: client pipes, weighted arbiter and output slice
`default_nettype none
`timescale 1ns/100ps

`include "rd_ig_config.svh"

module rd_ig_arb_top
  import rd_ig_arb_pkg::*;
  import rd_ig_req_pkg::*;
(
  input  logic                             nvdla_core_clk,
  input  logic                             nvdla_core_rstn,
  input  client_mask_t                     client_req_valid,
  input  rd_req_t [`RD_IG_NUM_CLIENTS-1:0] client_req_pd,
  output client_mask_t                     client_req_ready,
  input  weight_t [`RD_IG_NUM_CLIENTS-1:0] client_rd_wt,
  output logic                             spt_req_valid,
  output spt_req_t                         spt_req_pd,
  input  logic                             spt_req_ready
);

  client_mask_t                     src_valid;  // pipe outputs
  rd_req_t [`RD_IG_NUM_CLIENTS-1:0] src_pd;
  client_mask_t                     src_ready;  // one-hot grant
  logic                             arb_valid;
  spt_req_t                         arb_pd;
  logic                             arb_ready;

  // ====================
  // client pipes
  // ====================
  for (genvar i = 0; i < `RD_IG_NUM_CLIENTS; i++) begin : g_pipe
    rd_ig_skid_pipe pipe_i (
      .nvdla_core_clk  (nvdla_core_clk),
      .nvdla_core_rstn (nvdla_core_rstn),
      .in_valid        (client_req_valid[i]),
      .in_pd           (client_req_pd[i]),
      .in_ready        (client_req_ready[i]),
      .out_valid       (src_valid[i]),
      .out_pd          (src_pd[i]),
      .out_ready       (src_ready[i])
    );
  end

  // ====================
  // arbiter
  // ====================
  rd_ig_wrr_arb arb_i (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .src_valid       (src_valid),
    .src_pd          (src_pd),
    .weight          (client_rd_wt),  // static, sampled every cycle
    .src_ready       (src_ready),
    .arb_valid       (arb_valid),
    .arb_pd          (arb_pd),
    .arb_ready       (arb_ready)
  );

  // registered boundary toward the splitter
  rd_ig_out_stage out_i (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .arb_valid       (arb_valid),
    .arb_pd          (arb_pd),
    .arb_ready       (arb_ready),
    .spt_req_valid   (spt_req_valid),
    .spt_req_pd      (spt_req_pd),
    .spt_req_ready   (spt_req_ready)
  );

endmodule

`default_nettype wire

// File: hw/rd_ig_config.svh
// read ingress arbiter config: client count and request field widths
`ifndef RD_IG_CONFIG_SVH
`define RD_IG_CONFIG_SVH

// ====================
// client count
// ====================
// dma read clients feeding the arbiter, 2 to 16
`define RD_IG_NUM_CLIENTS 4

// ====================
// request fields
// ====================
// byte address of a read
`define RD_IG_ADDR_WIDTH 32

// length in 32-byte atoms minus one
`define RD_IG_SIZE_WIDTH 11

`endif

// File: hw/rd_ig_out_stage.sv
// read ingress output slice: one registered entry toward the splitter
`default_nettype none
`timescale 1ns/100ps

module rd_ig_out_stage
  import rd_ig_req_pkg::*;
(
  input  logic     nvdla_core_clk,
  input  logic     nvdla_core_rstn,
  input  logic     arb_valid,
  input  spt_req_t arb_pd,
  output logic     arb_ready,
  output logic     spt_req_valid,
  output spt_req_t spt_req_pd,
  input  logic     spt_req_ready
);

  logic load;  // winning request enters the slice

  // ====================
  // back-pressure
  // ====================
  // room when empty or draining this cycle
  assign arb_ready = !spt_req_valid || spt_req_ready;
  assign load      = arb_valid && arb_ready;

  // ====================
  // output register
  // ====================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      spt_req_valid <= 1'b0;
    end else if (load) begin
      spt_req_valid <= 1'b1;
    end else if (spt_req_ready) begin
      spt_req_valid <= 1'b0;  // drained, nothing new
    end
  end

  // held while the splitter stalls
  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      spt_req_pd <= arb_pd;
    end
  end

endmodule

`default_nettype wire

// File: hw/rd_ig_req_pkg.sv
// read ingress request types: client payload and its tagged downstream form
`default_nettype none

`include "rd_ig_config.svh"

package rd_ig_req_pkg;
  import rd_ig_arb_pkg::*;

  // ====================
  // request fields
  // ====================
  typedef logic [`RD_IG_ADDR_WIDTH-1:0] addr_t;  // byte address
  typedef logic [`RD_IG_SIZE_WIDTH-1:0] size_t;  // atoms minus one

  // client request payload, 43 bits with the default widths
  typedef struct packed {
    addr_t addr;
    size_t size;
  } rd_req_t;

  // ====================
  // downstream form
  // ====================
  // request toward the splitter, tagged with its source
  typedef struct packed {
    client_id_t id;   // winning client
    rd_req_t    req;  // untouched payload
  } spt_req_t;

endpackage

`default_nettype wire

// File: hw/rd_ig_skid_pipe.sv
// read ingress client pipe: valid-ready stage with bubble collapse and skid buffer
`default_nettype none
`timescale 1ns/100ps

module rd_ig_skid_pipe
  import rd_ig_req_pkg::*;
(
  input  logic    nvdla_core_clk,
  input  logic    nvdla_core_rstn,
  input  logic    in_valid,
  input  rd_req_t in_pd,
  output logic    in_ready,
  output logic    out_valid,
  output rd_req_t out_pd,
  input  logic    out_ready
);

  logic    pipe_valid;     // main register holds a request
  rd_req_t pipe_pd;
  logic    pipe_ready_bc;  // ready with bubble collapse
  logic    skid_valid;     // skid register holds a request
  rd_req_t skid_pd;
  logic    skid_catch;     // pipe data in flight, output stalled
  logic    skid_ready;
  logic    skid_ready_q;   // registered ready, also selects the output

  // ====================
  // pipe register
  // ====================
  // an empty register takes data even while stalled
  assign pipe_ready_bc = skid_ready_q || !pipe_valid;
  assign in_ready      = pipe_ready_bc;  // flop based, no path from out_ready

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else if (pipe_ready_bc) begin
      pipe_valid <= in_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && in_valid) begin
      pipe_pd <= in_pd;
    end
  end

  // ====================
  // skid buffer
  // ====================
  // catch when the output stalls while the pipe still advances
  assign skid_catch = pipe_valid && skid_ready_q && !out_ready;
  assign skid_ready = skid_valid ? out_ready : !skid_catch;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid   <= 1'b0;
      skid_ready_q <= 1'b1;  // ready out of reset
    end else begin
      skid_valid   <= skid_valid ? !out_ready : skid_catch;
      skid_ready_q <= skid_ready;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_pd <= pipe_pd;
    end
  end

  // skid entry is older, it goes first
  assign out_valid = skid_ready_q ? pipe_valid : skid_valid;
  assign out_pd    = skid_ready_q ? pipe_pd    : skid_pd;

endmodule

`default_nettype wire

// File: hw/rd_ig_wrr_arb.sv
// read ingress weighted round-robin arbiter with payload select and id tagging
`default_nettype none
`timescale 1ns/100ps

`include "rd_ig_config.svh"

module rd_ig_wrr_arb
  import rd_ig_arb_pkg::*;
  import rd_ig_req_pkg::*;
(
  input  logic                                nvdla_core_clk,
  input  logic                                nvdla_core_rstn,
  input  client_mask_t                        src_valid,
  input  rd_req_t [`RD_IG_NUM_CLIENTS-1:0]    src_pd,
  input  weight_t [`RD_IG_NUM_CLIENTS-1:0]    weight,
  output client_mask_t                        src_ready,
  output logic                                arb_valid,
  output spt_req_t                            arb_pd,
  input  logic                                arb_ready
);

  localparam int NUM = `RD_IG_NUM_CLIENTS;

  client_id_t   ptr;        // client holding the turn
  weight_t      cnt;        // grants used in this turn
  logic         cur_valid;  // current client requesting
  weight_t      cur_wt;
  weight_t      cur_lim;    // weight with 0 read as 1
  logic         keep_cur;   // current client keeps the turn
  client_id_t   nxt_id;     // next valid client after ptr
  client_id_t   gnt_id;
  client_mask_t gnt;        // one-hot or zero
  rd_req_t      gnt_req;

  // ====================
  // current client
  // ====================
  always_comb begin
    cur_valid = 1'b0;
    cur_wt    = '0;
    for (int i = 0; i < NUM; i++) begin
      if (client_id_t'(i) == ptr) begin
        cur_valid = src_valid[i];
        cur_wt    = weight[i];
      end
    end
  end

  assign cur_lim  = (cur_wt == '0) ? weight_t'(1) : cur_wt;
  assign keep_cur = cur_valid && (cnt < cur_lim);

  // ====================
  // round-robin search
  // ====================
  // scan far to near so the closest valid client wins
  // offset NUM lands on ptr itself, last choice
  always_comb begin
    int idx;
    nxt_id = ptr;  // nobody valid, stay put
    for (int off = NUM; off >= 1; off--) begin
      idx = (int'(ptr) + off) % NUM;
      if (src_valid[idx]) begin
        nxt_id = client_id_t'(idx);
      end
    end
  end

  assign gnt_id    = keep_cur ? ptr : nxt_id;
  assign arb_valid = arb_ready && (|src_valid);  // downstream busy, no grant

  // ====================
  // grant and payload mux
  // ====================
  always_comb begin
    gnt     = '0;
    gnt_req = '0;
    for (int i = 0; i < NUM; i++) begin
      gnt[i] = arb_valid && (client_id_t'(i) == gnt_id);
      if (gnt[i]) begin
        gnt_req = src_pd[i];
      end
    end
  end

  assign src_ready  = gnt;      // grant pops the client pipe
  assign arb_pd.id  = gnt_id;   // tag for the return path
  assign arb_pd.req = gnt_req;

  // pointer and counter only move on a grant
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ptr <= '0;
      cnt <= '0;
    end else if (arb_valid) begin
      if (keep_cur) begin
        cnt <= cnt + 1'b1;
      end else begin
        ptr <= nxt_id;        // new turn
        cnt <= weight_t'(1);  // this grant counts
      end
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the read ingress arbiter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rd_ig -f build.f -o sim_rd_ig

out=$(./obj_dir/sim_rd_ig || true)
printf '%s\n' "$out"

# pass only if the testbench reported it
echo "$out" | grep -q "ALL TESTS PASSED"

// File: testbench/rd_ig_props.sv
// read ingress handshake and grant properties, bound into the arbiter and output slice
`default_nettype none
`timescale 1ns/100ps

module rd_ig_props
  import rd_ig_arb_pkg::*;
  import rd_ig_req_pkg::*;
(
  input logic         nvdla_core_clk,
  input logic         nvdla_core_rstn,
  input logic         valid,  // hop valid
  input spt_req_t     pd,     // hop payload
  input logic         ready,  // hop ready
  input client_mask_t gnt     // client grants, zero where none exist
);

  // ====================
  // handshake
  // ====================
  // stalled request keeps valid and payload
  hold_while_stalled: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    valid && !ready |=> valid && $stable(pd)
  ) else $error("request changed while stalled");

  // first edge out of reset
  idle_after_reset: assert property (
    @(posedge nvdla_core_clk) $rose(nvdla_core_rstn) |-> !valid
  ) else $error("valid high right after reset");

  // ====================
  // grants
  // ====================
  grant_onehot: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $onehot0(gnt)
  ) else $error("more than one client granted");

  no_grant_when_busy: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !ready |-> (gnt == '0)
  ) else $error("grant while downstream busy");

endmodule

`default_nettype wire

// File: testbench/tb_rd_ig.sv
// testbench for the read ingress arbiter: random traffic against a per-client queue model
`default_nettype none
`timescale 1ns/100ps

`include "rd_ig_config.svh"

module tb_rd_ig
  import rd_ig_arb_pkg::*;
  import rd_ig_req_pkg::*;
();

  localparam int NUM     = `RD_IG_NUM_CLIENTS;
  localparam int TIMEOUT = 2000;  // cycles per wait loop

  logic              nvdla_core_clk;
  logic              nvdla_core_rstn;
  client_mask_t      client_req_valid;
  rd_req_t [NUM-1:0] client_req_pd;
  client_mask_t      client_req_ready;
  weight_t [NUM-1:0] client_rd_wt;
  logic              spt_req_valid;
  spt_req_t          spt_req_pd;
  logic              spt_req_ready;

  integer       seed;
  rd_req_t      model_q [NUM][$];  // accepted, not yet seen downstream
  client_mask_t acc;               // offers taken at the coming edge
  int           pass_cnt, fail_cnt, err_cnt, out_cnt;
  logic         gen_on;            // new requests allowed
  int           valid_pct, ready_pct;
  logic         seq_on;            // check weighted id order
  int           exp_id, exp_cnt;
  logic         hold_valid;        // output stalled last cycle
  spt_req_t     hold_pd;

  initial nvdla_core_clk = 1'b0;
  always #10 nvdla_core_clk = ~nvdla_core_clk;  // 20 ns

  rd_ig_arb_top dut_i (.*);

  bind rd_ig_wrr_arb rd_ig_props arb_props_i (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .valid          (arb_valid),
    .pd             (arb_pd),
    .ready          (arb_ready),
    .gnt            (src_ready)
  );

  bind rd_ig_out_stage rd_ig_props out_props_i (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .valid          (spt_req_valid),
    .pd             (spt_req_pd),
    .ready          (spt_req_ready),
    .gnt            ('0)              // no grants at this hop
  );

  // ====================
  // helpers
  // ====================
  function automatic int roll();
    return $unsigned($random(seed)) % 100;  // 0..99
  endfunction

  function automatic logic pending();
    logic busy;
    busy = |client_req_valid;
    for (int i = 0; i < NUM; i++) begin
      if (model_q[i].size() != 0) busy = 1'b1;
    end
    return busy;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t: %s, got %0h expected %0h", $time, what, actual, expected);
      err_cnt++;
    end
  endtask

  task automatic apply_reset();
    nvdla_core_rstn  = 1'b0;
    client_req_valid = '0;
    spt_req_ready    = 1'b0;
    acc        = '0;
    hold_valid = 1'b0;
    seq_on     = 1'b0;
    exp_id     = 0;
    exp_cnt    = 0;
    out_cnt    = 0;
    err_cnt    = 0;
    for (int i = 0; i < NUM; i++) model_q[i].delete();
    repeat (8) @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
  endtask

  // one cycle: drive on the falling edge, log what fires at the next rising edge
  task automatic drive_cycle();
    spt_req_t got;
    int       cid;
    int       lim;
    @(negedge nvdla_core_clk);
    if (hold_valid) begin  // stalled output must not move
      check_value(spt_req_valid, 1'b1, "valid dropped under back-pressure");
      check_value(spt_req_pd, hold_pd, "pd changed under back-pressure");
    end
    for (int i = 0; i < NUM; i++) begin
      if (!client_req_valid[i] || acc[i]) begin  // free to offer something new
        client_req_valid[i]    = gen_on && (roll() < valid_pct);
        client_req_pd[i].addr  = addr_t'($random(seed));
        client_req_pd[i].size  = size_t'($random(seed));
      end
    end
    spt_req_ready = roll() < ready_pct;
    for (int i = 0; i < NUM; i++) begin
      acc[i] = client_req_valid[i] && client_req_ready[i];  // ready is registered
      if (acc[i]) model_q[i].push_back(client_req_pd[i]);
    end
    if (spt_req_valid && spt_req_ready) begin
      got = spt_req_pd;
      cid = int'(got.id);
      if (cid >= NUM || model_q[cid].size() == 0) begin
        $display("client %0d sent a request the model never accepted", cid);
        err_cnt++;
      end else begin
        check_value(got.req, model_q[cid].pop_front(), "payload differs from model");
      end
      if (seq_on) begin
        check_value(got.id, exp_id, "weighted order broken");
        lim = (client_rd_wt[exp_id] == '0) ? 1 : int'(client_rd_wt[exp_id]);  // 0 acts as 1
        exp_cnt++;
        if (exp_cnt >= lim) begin
          exp_cnt = 0;
          exp_id  = (exp_id + 1) % NUM;
        end
      end
      out_cnt++;
    end
    hold_valid = spt_req_valid && !spt_req_ready;
    hold_pd    = spt_req_pd;
  endtask

  task automatic drain(input string name);
    int waited;
    gen_on    = 1'b0;
    ready_pct = 100;
    waited    = 0;
    while (pending() && waited < TIMEOUT) begin
      drive_cycle();
      waited++;
    end
    if (pending()) begin
      $display("%s: requests still pending after %0d cycles", name, TIMEOUT);
      err_cnt++;
    end
  endtask

  task automatic run_random(input string name, input int vpct, input int rpct);
    gen_on    = 1'b1;
    valid_pct = vpct;
    ready_pct = rpct;
    repeat (300) drive_cycle();
    drain(name);
  endtask

  // all clients saturated, splitter stalled 10 cycles then always ready
  task automatic run_saturated(input string name);
    int target, waited;
    target = 0;
    for (int i = 0; i < NUM; i++) begin
      target += (client_rd_wt[i] == '0) ? 1 : int'(client_rd_wt[i]);
    end
    target    = 3 * target;  // three full rounds
    gen_on    = 1'b1;
    valid_pct = 100;
    ready_pct = 0;
    seq_on    = 1'b1;
    repeat (10) drive_cycle();
    ready_pct = 100;
    waited    = 0;
    while (out_cnt < target && waited < TIMEOUT) begin
      drive_cycle();
      waited++;
    end
    if (out_cnt < target) begin
      $display("%s: only %0d of %0d outputs before the timeout", name, out_cnt, target);
      err_cnt++;
    end
    seq_on = 1'b0;  // order skews once clients stop
    drain(name);
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == 0) begin
      pass_cnt++;
      $display("test %s: pass, %0d outputs", name, out_cnt);
    end else begin
      fail_cnt++;
      $display("test %s: fail, %0d errors", name, err_cnt);
    end
  endtask

  // ====================
  // test sequence
  // ====================
  initial begin
    seed             = 93231;
    pass_cnt         = 0;
    fail_cnt         = 0;
    nvdla_core_rstn  = 1'b0;
    client_req_valid = '0;
    client_req_pd    = '0;
    client_rd_wt     = '0;
    spt_req_ready    = 1'b0;
    gen_on = 1'b0;
    valid_pct = 0;
    ready_pct = 0;
    hold_pd   = '0;

    apply_reset();
    repeat (4) begin
      @(negedge nvdla_core_clk);
      check_value(spt_req_valid, 1'b0, "output valid after reset");
      check_value(client_req_ready, {NUM{1'b1}}, "client ready after reset");
    end
    finish_test("reset");

    for (int i = 0; i < NUM; i++) client_rd_wt[i] = weight_t'($unsigned($random(seed)) % 6);
    apply_reset();
    run_random("integrity", 60, 75);
    finish_test("integrity");

    for (int i = 0; i < NUM; i++) client_rd_wt[i] = weight_t'(1 + $unsigned($random(seed)) % 5);
    apply_reset();
    run_saturated("weighted_order");
    finish_test("weighted_order");

    client_rd_wt[$unsigned($random(seed)) % NUM] = '0;  // one client at weight 0
    apply_reset();
    run_saturated("zero_weight");
    finish_test("zero_weight");

    apply_reset();
    run_random("back_pressure", 70, 30);
    finish_test("back_pressure");

    $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
